// File: logic/eth_frame_pkg.sv
package eth_frame_pkg;

    // mac header without preamble, sfd or vlan tag.
    localparam int HEADER_BYTES = 14;

    // window shifts in at the low byte, so the sfd lands in bits 7:0.
    localparam logic [63:0] PREAMBLE_SFD = 64'h5555_5555_5555_55d5;

    localparam logic [47:0] BROADCAST_MAC = 48'hffff_ffff_ffff;

    // parser states, one per section of the frame on the wire.
    localparam logic [1:0] PARSE_IDLE     = 2'd0;
    localparam logic [1:0] PARSE_PREAMBLE = 2'd1;
    localparam logic [1:0] PARSE_HEADER   = 2'd2;
    localparam logic [1:0] PARSE_PAYLOAD  = 2'd3;

    // bytes[13] is the first byte received, the top of mac_destination.
    typedef union packed {
        logic [HEADER_BYTES-1:0][7:0] bytes;
        struct packed {
            logic [47:0] mac_destination;
            logic [47:0] mac_source;
            logic [15:0] ethertype;
        } fields;
    } eth_header_u;

endpackage

// File: logic/rx_regs_pkg.sv
package rx_regs_pkg;

    // register map.
    localparam logic [2:0] REG_MAC_LO         = 3'd0;
    localparam logic [2:0] REG_MAC_HI         = 3'd1;
    localparam logic [2:0] REG_CTRL           = 3'd2;
    localparam logic [2:0] REG_ACCEPT_COUNT   = 3'd3;
    localparam logic [2:0] REG_DROP_COUNT     = 3'd4;
    localparam logic [2:0] REG_OVERFLOW_COUNT = 3'd5;

    // bit positions in REG_CTRL.
    localparam int         CTRL_FILTER_EN    = 0;
    localparam int         CTRL_ACCEPT_BCAST = 1;
    localparam logic [1:0] CTRL_RESET        = 2'b11;

    // payload buffer, depth must stay a power of two.
    localparam int FIFO_DEPTH     = 64;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    // credits held by the buffer after reset.
    localparam int CREDIT_INIT = 4;
    localparam int CREDIT_BITS = $clog2(CREDIT_INIT + 1);

endpackage

// File: logic/rx_config_regs.sv
`timescale 1ns/10ps

module rx_config_regs (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cfg_we_i,
    input  logic [2:0]  cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    input  logic        frame_accepted_i,
    input  logic        frame_dropped_i,
    input  logic        overflow_i,
    output logic [47:0] station_mac_o,
    output logic        filter_en_o,
    output logic        accept_bcast_o
);

    logic [47:0] mac_q;
    logic [1:0]  ctrl_q;
    logic [31:0] accept_count_q;
    logic [31:0] drop_count_q;
    logic [31:0] overflow_count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mac_q  <= '0;
            ctrl_q <= rx_regs_pkg::CTRL_RESET;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                rx_regs_pkg::REG_MAC_LO: mac_q[31:0] <= cfg_wdata_i;
                rx_regs_pkg::REG_MAC_HI: mac_q[47:32] <= cfg_wdata_i[15:0];
                rx_regs_pkg::REG_CTRL:   ctrl_q <= cfg_wdata_i[1:0];
                default: ;
            endcase
        end
    end

    // counters wrap, software takes differences.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            accept_count_q   <= '0;
            drop_count_q     <= '0;
            overflow_count_q <= '0;
        end else begin
            if (frame_accepted_i) begin
                accept_count_q <= accept_count_q + 32'd1;
            end
            if (frame_dropped_i) begin
                drop_count_q <= drop_count_q + 32'd1;
            end
            if (overflow_i) begin
                overflow_count_q <= overflow_count_q + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            rx_regs_pkg::REG_MAC_LO:         cfg_rdata_o = mac_q[31:0];
            rx_regs_pkg::REG_MAC_HI:         cfg_rdata_o = {16'h0000, mac_q[47:32]};
            rx_regs_pkg::REG_CTRL:           cfg_rdata_o = {30'd0, ctrl_q};
            rx_regs_pkg::REG_ACCEPT_COUNT:   cfg_rdata_o = accept_count_q;
            rx_regs_pkg::REG_DROP_COUNT:     cfg_rdata_o = drop_count_q;
            rx_regs_pkg::REG_OVERFLOW_COUNT: cfg_rdata_o = overflow_count_q;
            default:                         cfg_rdata_o = '0;
        endcase
    end

    assign station_mac_o  = mac_q;
    assign filter_en_o    = ctrl_q[rx_regs_pkg::CTRL_FILTER_EN];
    assign accept_bcast_o = ctrl_q[rx_regs_pkg::CTRL_ACCEPT_BCAST];

endmodule

// File: logic/gmii_frame_parser.sv
`timescale 1ns/10ps

module gmii_frame_parser (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic [47:0] station_mac_i,
    input  logic        filter_en_i,
    input  logic        accept_bcast_i,
    output logic [7:0]  byte_o,
    output logic        byte_valid_o,
    output logic        byte_last_o,
    output logic        frame_accepted_o,
    output logic        frame_dropped_o
);

    localparam logic [3:0] HDR_LAST = 4'(eth_frame_pkg::HEADER_BYTES - 1);

    logic [2:0][7:0] rxd_z;
    logic [2:0]      rxdv_z;
    logic            frame_start;
    logic            frame_end;
    logic [1:0]      state_q;
    logic [1:0]      state_d;
    logic [63:0]     window_q;
    logic [63:0]     window_next;
    logic [3:0]      hdr_count_q;
    logic            dest_match;
    logic            accept_q;

    eth_frame_pkg::eth_header_u header_q;
    eth_frame_pkg::eth_header_u header_next;

    // three stage input delay, the data path is not reset.
    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    // stage 1 looks one byte ahead of stage 2, so frame_end flags the
    // byte in stage 2 as the final one.
    assign frame_start = !rxdv_z[2] && rxdv_z[1];
    assign frame_end   = rxdv_z[2] && !rxdv_z[1];

    assign window_next = {window_q[55:0], rxd_z[2]};

    always_comb begin
        header_next.bytes = {header_q.bytes[eth_frame_pkg::HEADER_BYTES-2:0], rxd_z[2]};
        dest_match = !filter_en_i
            || (header_next.fields.mac_destination == station_mac_i)
            || (accept_bcast_i
                && header_next.fields.mac_destination == eth_frame_pkg::BROADCAST_MAC);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            eth_frame_pkg::PARSE_IDLE: begin
                if (frame_start) begin
                    state_d = eth_frame_pkg::PARSE_PREAMBLE;
                end
            end
            eth_frame_pkg::PARSE_PREAMBLE: begin
                if (frame_end) begin
                    state_d = eth_frame_pkg::PARSE_IDLE;
                end else if (window_next == eth_frame_pkg::PREAMBLE_SFD) begin
                    state_d = eth_frame_pkg::PARSE_HEADER;
                end
            end
            eth_frame_pkg::PARSE_HEADER: begin
                // runt frame, back to idle with no decision.
                if (frame_end) begin
                    state_d = eth_frame_pkg::PARSE_IDLE;
                end else if (hdr_count_q == HDR_LAST) begin
                    state_d = eth_frame_pkg::PARSE_PAYLOAD;
                end
            end
            eth_frame_pkg::PARSE_PAYLOAD: begin
                if (frame_end) begin
                    state_d = eth_frame_pkg::PARSE_IDLE;
                end
            end
            default: state_d = eth_frame_pkg::PARSE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q          <= eth_frame_pkg::PARSE_IDLE;
            window_q         <= '0;
            hdr_count_q      <= '0;
            accept_q         <= 1'b0;
            byte_valid_o     <= 1'b0;
            byte_last_o      <= 1'b0;
            frame_accepted_o <= 1'b0;
            frame_dropped_o  <= 1'b0;
        end else begin
            state_q          <= state_d;
            byte_valid_o     <= 1'b0;
            byte_last_o      <= 1'b0;
            frame_accepted_o <= 1'b0;
            frame_dropped_o  <= 1'b0;
            // cleared outside the hunt so an old match cannot repeat.
            if (state_q == eth_frame_pkg::PARSE_PREAMBLE) begin
                window_q <= window_next;
            end else begin
                window_q <= '0;
            end
            if (state_q == eth_frame_pkg::PARSE_HEADER) begin
                hdr_count_q <= hdr_count_q + 4'd1;
            end else begin
                hdr_count_q <= '0;
            end
            // decide once, on the last header byte.
            if (state_q == eth_frame_pkg::PARSE_HEADER && hdr_count_q == HDR_LAST
                    && !frame_end) begin
                accept_q         <= dest_match;
                frame_accepted_o <= dest_match;
                frame_dropped_o  <= !dest_match;
            end
            if (state_q == eth_frame_pkg::PARSE_PAYLOAD && accept_q) begin
                byte_valid_o <= 1'b1;
                byte_last_o  <= frame_end;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == eth_frame_pkg::PARSE_HEADER) begin
            header_q <= header_next;
        end
        byte_o <= rxd_z[2];
    end

endmodule

// File: logic/rx_credit_fifo.sv
`timescale 1ns/10ps

module rx_credit_fifo (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [7:0] byte_i,
    input  logic       byte_valid_i,
    input  logic       byte_last_i,
    input  logic       credit_i,
    output logic [7:0] data_o,
    output logic       valid_o,
    output logic       last_o,
    output logic       overflow_o
);

    logic [8:0] ring_q [rx_regs_pkg::FIFO_DEPTH];

    logic [rx_regs_pkg::FIFO_ADDR_BITS-1:0] wr_ptr_q;
    logic [rx_regs_pkg::FIFO_ADDR_BITS-1:0] rd_ptr_q;
    logic [rx_regs_pkg::FIFO_ADDR_BITS:0]   fill_q;
    logic [rx_regs_pkg::CREDIT_BITS-1:0]    credit_q;
    logic                                   full;
    logic                                   wr_en;
    logic                                   rd_en;
    logic [8:0]                             head;

    assign full  = fill_q == rx_regs_pkg::FIFO_DEPTH[rx_regs_pkg::FIFO_ADDR_BITS:0];
    assign wr_en = byte_valid_i && !full;

    // a byte goes out only while a credit is held.
    assign rd_en = (credit_q != '0) && (fill_q != '0);

    // no read slot is freed for a write that finds the ring full.
    assign overflow_o = byte_valid_i && full;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            ring_q[wr_ptr_q] <= {byte_last_i, byte_i};
        end
    end

    // pointers wrap on their own since depth is a power of two.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    // spend and return in one cycle cancel out.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= rx_regs_pkg::CREDIT_INIT[rx_regs_pkg::CREDIT_BITS-1:0];
        end else begin
            case ({rd_en, credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    assign head    = ring_q[rd_ptr_q];
    assign data_o  = head[7:0];
    assign last_o  = head[8];
    assign valid_o = rd_en;

endmodule

// File: logic/eth_rx_top.sv
`timescale 1ns/10ps

module eth_rx_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic        cfg_we_i,
    input  logic [2:0]  cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    output logic [7:0]  data_o,
    output logic        valid_o,
    output logic        last_o,
    input  logic        credit_i
);

    logic [47:0] station_mac;
    logic        filter_en;
    logic        accept_bcast;
    logic [7:0]  rx_byte;
    logic        rx_byte_valid;
    logic        rx_byte_last;
    logic        frame_accepted;
    logic        frame_dropped;
    logic        overflow;

    rx_config_regs u_regs (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .cfg_rdata_o      (cfg_rdata_o),
        .frame_accepted_i (frame_accepted),
        .frame_dropped_i  (frame_dropped),
        .overflow_i       (overflow),
        .station_mac_o    (station_mac),
        .filter_en_o      (filter_en),
        .accept_bcast_o   (accept_bcast)
    );

    gmii_frame_parser u_parser (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .rx_d_i           (rx_d_i),
        .rx_dv_i          (rx_dv_i),
        .station_mac_i    (station_mac),
        .filter_en_i      (filter_en),
        .accept_bcast_i   (accept_bcast),
        .byte_o           (rx_byte),
        .byte_valid_o     (rx_byte_valid),
        .byte_last_o      (rx_byte_last),
        .frame_accepted_o (frame_accepted),
        .frame_dropped_o  (frame_dropped)
    );

    rx_credit_fifo u_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_i       (rx_byte),
        .byte_valid_i (rx_byte_valid),
        .byte_last_i  (rx_byte_last),
        .credit_i     (credit_i),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .last_o       (last_o),
        .overflow_o   (overflow)
    );

endmodule

// File: tests/eth_rx_assert.sv
`timescale 1ns/10ps

module eth_rx_assert (
    input logic                                clk_i,
    input logic                                rst_i,
    input logic                                valid_i,
    input logic                                credit_i,
    input logic [rx_regs_pkg::CREDIT_BITS-1:0] credit_count_i,
    input logic                                overflow_i,
    input logic                                byte_valid_i
);

    int credits_held;
    int bytes_stored;

    // credits and ring fill as seen from the ports alone.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits_held <= rx_regs_pkg::CREDIT_INIT;
            bytes_stored <= 0;
        end else begin
            credits_held <= credits_held - int'(valid_i) + int'(credit_i);
            bytes_stored <= bytes_stored + int'(byte_valid_i && !overflow_i) - int'(valid_i);
        end
    end

    // a byte never leaves without a credit in hand.
    no_byte_without_credit: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_i |-> credits_held > 0
    ) else $error("valid_o high while no credit is held");

    // the consumer can only return what it was sent.
    credit_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
            credit_count_i <= rx_regs_pkg::CREDIT_INIT[rx_regs_pkg::CREDIT_BITS-1:0]
    ) else $error("credit count above its initial value");

    overflow_needs_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
            overflow_i |-> byte_valid_i && bytes_stored == rx_regs_pkg::FIFO_DEPTH
    ) else $error("overflow_o high without an incoming byte or with room in the ring");

endmodule

bind rx_credit_fifo eth_rx_assert u_assert (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (valid_o),
    .credit_i       (credit_i),
    .credit_count_i (credit_q),
    .overflow_i     (overflow_o),
    .byte_valid_i   (byte_valid_i)
);

// File: tests/eth_rx_tb.sv
`timescale 1ns/10ps

module eth_rx_tb;

    localparam logic [47:0] STATION_MAC = 48'h0200_5e10_2030;
    localparam logic [47:0] OTHER_MAC   = 48'h0200_5e10_2031;
    localparam logic [47:0] SOURCE_MAC  = 48'h0a1b_2c3d_4e5f;
    localparam int          HB          = eth_frame_pkg::HEADER_BYTES;

    logic        clk_i;
    logic        rst_i;
    logic [7:0]  rx_d_i;
    logic        rx_dv_i;
    logic        cfg_we_i;
    logic [2:0]  cfg_addr_i;
    logic [31:0] cfg_wdata_i;
    logic [31:0] cfg_rdata_o;
    logic [7:0]  data_o;
    logic        valid_o;
    logic        last_o;
    logic        credit_i = 1'b0;

    logic [31:0] rng_state = 32'd37009;
    logic [7:0]  expect_q[$];
    logic [7:0]  got_data[$];
    logic        got_last[$];
    int          bytes_seen = 0;
    int          credits_returned = 0;
    logic        return_credits = 1'b1;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] exp_accept = '0;
    logic [31:0] exp_drop = '0;
    logic [31:0] exp_overflow = '0;

    eth_rx_top uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rx_d_i      (rx_d_i),
        .rx_dv_i     (rx_dv_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .data_o      (data_o),
        .valid_o     (valid_o),
        .last_o      (last_o),
        .credit_i    (credit_i)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // output bytes are taken mid-cycle, where they are stable.
    always @(negedge clk_i) begin
        if (!rst_i && valid_o) begin
            got_data.push_back(data_o);
            got_last.push_back(last_o);
            bytes_seen = bytes_seen + 1;
        end
    end

    // one credit back per received byte, unless held.
    always @(posedge clk_i) begin
        if (return_credits && credits_returned < bytes_seen) begin
            credit_i         <= 1'b1;
            credits_returned <= credits_returned + 1;
        end else begin
            credit_i <= 1'b0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] ctrl_value(input logic filter, input logic bcast);
        logic [31:0] v;
        v = '0;
        v[rx_regs_pkg::CTRL_FILTER_EN]    = filter;
        v[rx_regs_pkg::CTRL_ACCEPT_BCAST] = bcast;
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(posedge clk_i);
        rx_dv_i <= 1'b1;
        rx_d_i  <= b;
    endtask

    // header_len below HB gives a runt that ends inside its header.
    task automatic send_frame(input logic [47:0] dest, input int payload_len,
                              input int header_len, input bit accepted);
        eth_frame_pkg::eth_header_u header;
        logic [7:0]                 b;
        header.fields.mac_destination = dest;
        header.fields.mac_source      = SOURCE_MAC;
        header.fields.ethertype       = 16'h0800;
        for (int i = 7; i >= 0; i--) begin
            drive_byte(eth_frame_pkg::PREAMBLE_SFD[i*8 +: 8]);
        end
        for (int i = 0; i < header_len; i++) begin
            drive_byte(header.bytes[HB-1-i]);
        end
        for (int i = 0; i < payload_len; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            drive_byte(b);
            if (accepted) begin
                expect_q.push_back(b);
            end
        end
        @(posedge clk_i);
        rx_dv_i <= 1'b0;
        rx_d_i  <= 8'h00;
        repeat (12) @(posedge clk_i);
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        @(posedge clk_i);
        cfg_addr_i <= addr;
        @(negedge clk_i);
        data = cfg_rdata_o;
    endtask

    task automatic check_reg(input logic [2:0] addr, input logic [31:0] expected,
                             input string what);
        logic [31:0] value;
        int          tries;
        tries = 0;
        read_reg(addr, value);
        while (value != expected && tries < 20) begin
            read_reg(addr, value);
            tries++;
        end
        check_value(value, expected, what);
    endtask

    task automatic check_output(input bit mark_last);
        int n;
        int cycles;
        n = expect_q.size();
        cycles = 0;
        while (got_data.size() < n && cycles < 2000) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (got_data.size() >= n) else begin
            timeouts++;
            $display("timed out waiting for %0d output bytes, %0d arrived", n, got_data.size());
        end
        // stray bytes would show up within a few cycles.
        repeat (8) @(posedge clk_i);
        check_value(got_data.size(), n, "output byte count");
        for (int i = 0; i < n && i < got_data.size(); i++) begin
            check_value({24'd0, got_data[i]}, {24'd0, expect_q[i]}, "output byte");
            check_value({31'd0, got_last[i]}, {31'd0, (mark_last && i == n - 1)}, "last_o");
        end
        expect_q.delete();
        got_data.delete();
        got_last.delete();
    endtask

    task automatic hold_credits();
        int cycles;
        cycles = 0;
        while (credits_returned != bytes_seen && cycles < 100) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (credits_returned == bytes_seen) else begin
            timeouts++;
            $display("credits were still owed when holding them back");
        end
        @(negedge clk_i);
        return_credits = 1'b0;
    endtask

    task automatic release_credits();
        @(negedge clk_i);
        return_credits = 1'b1;
    endtask

    task automatic check_counters();
        check_reg(rx_regs_pkg::REG_ACCEPT_COUNT, exp_accept, "accept count");
        check_reg(rx_regs_pkg::REG_DROP_COUNT, exp_drop, "drop count");
        check_reg(rx_regs_pkg::REG_OVERFLOW_COUNT, exp_overflow, "overflow count");
    endtask

    task automatic test_registers();
        check_counters();
        check_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b1), "control after reset");
        write_reg(rx_regs_pkg::REG_MAC_LO, STATION_MAC[31:0]);
        write_reg(rx_regs_pkg::REG_MAC_HI, {16'h0000, STATION_MAC[47:32]});
        write_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b0));
        check_reg(rx_regs_pkg::REG_MAC_LO, STATION_MAC[31:0], "mac low");
        check_reg(rx_regs_pkg::REG_MAC_HI, {16'h0000, STATION_MAC[47:32]}, "mac high");
        check_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b0), "control");
        write_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b1));
        // counters are read-only.
        write_reg(rx_regs_pkg::REG_DROP_COUNT, 32'h1234_5678);
        check_counters();
    endtask

    task automatic test_filtering();
        send_frame(OTHER_MAC, 16, HB, 1'b0);
        check_output(1'b1);
        exp_drop = exp_drop + 32'd1;
        send_frame(eth_frame_pkg::BROADCAST_MAC, 10, HB, 1'b1);
        check_output(1'b1);
        exp_accept = exp_accept + 32'd1;
        write_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b0));
        send_frame(eth_frame_pkg::BROADCAST_MAC, 10, HB, 1'b0);
        check_output(1'b1);
        exp_drop = exp_drop + 32'd1;
        write_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b0, 1'b0));
        send_frame(OTHER_MAC, 9, HB, 1'b1);
        check_output(1'b1);
        exp_accept = exp_accept + 32'd1;
        write_reg(rx_regs_pkg::REG_CTRL, ctrl_value(1'b1, 1'b1));
        check_counters();
    endtask

    task automatic test_credits_and_overflow();
        hold_credits();
        send_frame(STATION_MAC, 12, HB, 1'b1);
        check_value(got_data.size(), rx_regs_pkg::CREDIT_INIT, "bytes sent without credits");
        release_credits();
        check_output(1'b1);
        exp_accept = exp_accept + 32'd1;
        check_counters();
        // the ring fills after the first credits are spent, the rest is lost.
        hold_credits();
        send_frame(STATION_MAC, 100, HB, 1'b1);
        while (expect_q.size() > rx_regs_pkg::FIFO_DEPTH + rx_regs_pkg::CREDIT_INIT) begin
            void'(expect_q.pop_back());
        end
        exp_accept   = exp_accept + 32'd1;
        exp_overflow = exp_overflow
            + 32'(100 - rx_regs_pkg::FIFO_DEPTH - rx_regs_pkg::CREDIT_INIT);
        check_counters();
        release_credits();
        check_output(1'b0);
    endtask

    initial begin
        repeat (50000) @(posedge clk_i);
        $display("simulation limit reached before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_i       = 1'b1;
        rx_d_i      = 8'h00;
        rx_dv_i     = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = 3'd0;
        cfg_wdata_i = 32'd0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        test_registers();
        send_frame(STATION_MAC, 20, HB, 1'b1);
        check_output(1'b1);
        exp_accept = exp_accept + 32'd1;
        check_counters();
        test_filtering();
        test_credits_and_overflow();
        // runt frame, then a normal one.
        send_frame(STATION_MAC, 0, 8, 1'b0);
        check_output(1'b1);
        check_counters();
        send_frame(STATION_MAC, 24, HB, 1'b1);
        check_output(1'b1);
        exp_accept = exp_accept + 32'd1;
        check_counters();
        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/eth_frame_pkg.sv
logic/rx_regs_pkg.sv
logic/rx_config_regs.sv
logic/gmii_frame_parser.sv
logic/rx_credit_fifo.sv
logic/eth_rx_top.sv
tests/eth_rx_assert.sv
tests/eth_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module eth_rx_tb -f list.f -o eth_rx_sim \
    && ./obj_dir/eth_rx_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
